//--- cache_geom_pkg.sv
// --------------------------------------------------
// Cache geometry: address split, widths, data types
// --------------------------------------------------

package cache_geom_pkg;

  localparam int addr_w         = 32;
  localparam int word_w         = 32;
  localparam int words_per_line = 4;
  localparam int line_w         = words_per_line * word_w;  // 128
  localparam int offset_w       = 4;                        // Byte offset in a line
  localparam int word_sel_w     = 2;

  // Tag keeps every bit above the offset, so it doubles as line address
  localparam int tag_w          = addr_w - offset_w;

  // --------------------------------------------------
  // Data types
  // --------------------------------------------------

  typedef logic [addr_w-1:0]     addr_t;
  typedef logic [word_w-1:0]     word_t;
  typedef logic [line_w-1:0]     line_t;
  typedef logic [tag_w-1:0]      tag_t;
  typedef logic [word_sel_w-1:0] word_sel_t;

endpackage

//--- cache_ctrl_pkg.sv
// --------------------------------------------------
// Cache request opcodes and controller states
// --------------------------------------------------

package cache_ctrl_pkg;

  typedef enum logic [2:0] {
    req_read  = 3'd0,
    req_write = 3'd1,
    req_init  = 3'd2
  } req_type_e;

  typedef enum logic [3:0] {
    st_idle, st_tag_check,
    st_init_access, st_read_access, st_write_access,
    st_evict_prepare, st_evict_request, st_evict_wait,  // Dirty victim write-back
    st_refill_request, st_refill_wait, st_refill_update,
    st_resp_wait
  } ctrl_state_e;

endpackage

//--- cache_tag_store.sv
// --------------------------------------------------
// Two-way tag store with valid, dirty and LRU bits
// Combinational hit and victim lookup per set
// --------------------------------------------------

module cache_tag_store #(
  parameter int num_sets = 8
) (
  input  logic                 clk,
  input  logic                 reset,
  input  cache_geom_pkg::tag_t line_addr,
  input  logic                 install,
  input  logic                 set_dirty,
  input  logic                 touch,
  input  logic                 way,
  output logic                 hit,
  output logic                 hit_way,
  output logic                 victim_way,
  output logic                 victim_dirty,
  output cache_geom_pkg::tag_t victim_tag
);

  localparam int idx_w = $clog2(num_sets);

  cache_geom_pkg::tag_t tags [2][num_sets];
  logic [num_sets-1:0]  valid_q [2];
  logic [num_sets-1:0]  dirty_q [2];
  logic [num_sets-1:0]  lru_q;        // Points at the least recently used way

  logic [idx_w-1:0] idx;
  logic [1:0]       way_hit;

  assign idx = line_addr[idx_w-1:0];

  // --------------------------------------------------
  // Lookup
  // --------------------------------------------------

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      way_hit[w] = valid_q[w][idx] && (tags[w][idx] == line_addr);
    end
  end

  assign hit     = |way_hit;
  assign hit_way = way_hit[1];

  // Empty ways are filled before anything is replaced
  always_comb begin
    if (!valid_q[0][idx]) victim_way = 1'b0;
    else if (!valid_q[1][idx]) victim_way = 1'b1;
    else victim_way = lru_q[idx];
  end

  assign victim_dirty = dirty_q[victim_way][idx];
  assign victim_tag   = tags[victim_way][idx];

  // --------------------------------------------------
  // Updates
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (install) tags[way][idx] <= line_addr;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '{default: '0};
      dirty_q <= '{default: '0};
      lru_q   <= '0;
    end else begin
      if (install) begin
        valid_q[way][idx] <= 1'b1;
        dirty_q[way][idx] <= 1'b0;  // Fresh line matches memory
      end
      if (set_dirty) dirty_q[way][idx] <= 1'b1;
      if (touch) lru_q[idx] <= !way;
    end
  end

endmodule

//--- cache_data_store.sv
// --------------------------------------------------
// Line storage for both ways
// Word and full-line writes, combinational reads
// --------------------------------------------------

module cache_data_store #(
  parameter int num_sets = 8
) (
  input  logic                      clk,
  input  cache_geom_pkg::tag_t      line_addr,
  input  logic                      way,
  input  cache_geom_pkg::word_sel_t word_sel,
  input  logic                      word_write,
  input  logic                      line_write,
  input  cache_geom_pkg::word_t     wr_word,
  input  cache_geom_pkg::line_t     wr_line,
  output cache_geom_pkg::word_t     rd_word,
  output cache_geom_pkg::line_t     rd_line
);

  localparam int idx_w = $clog2(num_sets);
  localparam int ww    = cache_geom_pkg::word_w;

  cache_geom_pkg::line_t lines [2][num_sets];

  logic [idx_w-1:0] idx;

  assign idx = line_addr[idx_w-1:0];

  // Whole line of the chosen way, used for eviction too
  assign rd_line = lines[way][idx];
  assign rd_word = rd_line[word_sel*ww +: ww];

  always_ff @(posedge clk) begin
    if (line_write) begin
      lines[way][idx] <= wr_line;                 // Refill or init
    end else if (word_write) begin
      lines[way][idx][word_sel*ww +: ww] <= wr_word;
    end
  end

endmodule

//--- cache_ctrl.sv
// --------------------------------------------------
// Cache controller: request register and FSM for
// tag check, access, eviction and refill
// --------------------------------------------------

module cache_ctrl (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      cachereq_val,
  output logic                      cachereq_rdy,
  input  cache_ctrl_pkg::req_type_e cachereq_type,
  input  cache_geom_pkg::addr_t     cachereq_addr,
  input  cache_geom_pkg::word_t     cachereq_data,
  output logic                      cacheresp_val,
  input  logic                      cacheresp_rdy,
  output cache_ctrl_pkg::req_type_e cacheresp_type,
  output cache_geom_pkg::word_t     cacheresp_data,
  output logic                      cacheresp_hit,
  output logic                      memreq_val,
  input  logic                      memreq_rdy,
  output logic                      memreq_write,
  output cache_geom_pkg::addr_t     memreq_addr,
  output cache_geom_pkg::line_t     memreq_data,
  input  logic                      memresp_val,
  output logic                      memresp_rdy,
  input  cache_geom_pkg::line_t     memresp_data,
  input  logic                      hit,
  input  logic                      hit_way,
  input  logic                      victim_way,
  input  logic                      victim_dirty,
  input  cache_geom_pkg::tag_t      victim_tag,
  input  cache_geom_pkg::word_t     rd_word,
  input  cache_geom_pkg::line_t     rd_line,
  output cache_geom_pkg::tag_t      line_addr,
  output logic                      install,
  output logic                      set_dirty,
  output logic                      touch,
  output logic                      way,
  output cache_geom_pkg::word_sel_t word_sel,
  output logic                      word_write,
  output logic                      line_write,
  output cache_geom_pkg::word_t     wr_word,
  output cache_geom_pkg::line_t     wr_line
);

  localparam int ofs = cache_geom_pkg::offset_w;
  localparam int ww  = cache_geom_pkg::word_w;

  cache_ctrl_pkg::ctrl_state_e state_q, state_d;
  cache_ctrl_pkg::req_type_e   req_type_q;
  cache_geom_pkg::addr_t       req_addr_q;
  cache_geom_pkg::word_t       req_data_q;
  cache_geom_pkg::word_t       resp_data_q;
  cache_geom_pkg::line_t       refill_q;
  cache_geom_pkg::line_t       init_line;
  logic                        hit_q;
  logic                        way_q;

  // --------------------------------------------------
  // Registers
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) state_q <= cache_ctrl_pkg::st_idle;
    else state_q <= state_d;
  end

  always_ff @(posedge clk) begin
    if (cachereq_val && cachereq_rdy) begin
      req_type_q <= cachereq_type;
      req_addr_q <= cachereq_addr;
      req_data_q <= cachereq_data;
    end
    if (state_q == cache_ctrl_pkg::st_tag_check) begin
      hit_q <= hit;
      if (req_type_q == cache_ctrl_pkg::req_init) way_q <= 1'b0;  // Init always fills way 0
      else way_q <= hit ? hit_way : victim_way;
    end
    if (state_q == cache_ctrl_pkg::st_refill_wait && memresp_val) refill_q <= memresp_data;
    if (state_q == cache_ctrl_pkg::st_read_access) resp_data_q <= rd_word;
    else if (state_q == cache_ctrl_pkg::st_write_access ||
             state_q == cache_ctrl_pkg::st_init_access) resp_data_q <= '0;
  end

  // --------------------------------------------------
  // Next state
  // --------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      cache_ctrl_pkg::st_idle: if (cachereq_val) state_d = cache_ctrl_pkg::st_tag_check;
      cache_ctrl_pkg::st_tag_check: begin
        if (req_type_q == cache_ctrl_pkg::req_init) state_d = cache_ctrl_pkg::st_init_access;
        else if (hit && req_type_q == cache_ctrl_pkg::req_write)
          state_d = cache_ctrl_pkg::st_write_access;
        else if (hit) state_d = cache_ctrl_pkg::st_read_access;
        else if (victim_dirty) state_d = cache_ctrl_pkg::st_evict_prepare;
        else state_d = cache_ctrl_pkg::st_refill_request;
      end
      cache_ctrl_pkg::st_init_access,
      cache_ctrl_pkg::st_read_access,
      cache_ctrl_pkg::st_write_access: state_d = cache_ctrl_pkg::st_resp_wait;
      cache_ctrl_pkg::st_evict_prepare: state_d = cache_ctrl_pkg::st_evict_request;
      cache_ctrl_pkg::st_evict_request: if (memreq_rdy) state_d = cache_ctrl_pkg::st_evict_wait;
      cache_ctrl_pkg::st_evict_wait: if (memresp_val) state_d = cache_ctrl_pkg::st_refill_request;
      cache_ctrl_pkg::st_refill_request: if (memreq_rdy) state_d = cache_ctrl_pkg::st_refill_wait;
      cache_ctrl_pkg::st_refill_wait: if (memresp_val) state_d = cache_ctrl_pkg::st_refill_update;
      cache_ctrl_pkg::st_refill_update: begin
        // Line is now resident, so the access hits
        if (req_type_q == cache_ctrl_pkg::req_write) state_d = cache_ctrl_pkg::st_write_access;
        else state_d = cache_ctrl_pkg::st_read_access;
      end
      cache_ctrl_pkg::st_resp_wait: if (cacheresp_rdy) state_d = cache_ctrl_pkg::st_idle;
      default: state_d = cache_ctrl_pkg::st_idle;
    endcase
  end

  // --------------------------------------------------
  // Outputs
  // --------------------------------------------------

  always_comb begin
    init_line = '0;
    init_line[word_sel*ww +: ww] = req_data_q;
  end

  assign line_addr = req_addr_q[cache_geom_pkg::addr_w-1:ofs];
  assign word_sel  = req_addr_q[ofs-1:ofs-cache_geom_pkg::word_sel_w];
  assign way       = way_q;

  assign line_write = state_q == cache_ctrl_pkg::st_init_access ||
                      state_q == cache_ctrl_pkg::st_refill_update;
  assign install    = line_write;
  assign word_write = state_q == cache_ctrl_pkg::st_write_access;
  assign set_dirty  = word_write;
  assign touch      = state_q == cache_ctrl_pkg::st_read_access || word_write ||
                      state_q == cache_ctrl_pkg::st_init_access;
  assign wr_word    = req_data_q;
  assign wr_line    = (state_q == cache_ctrl_pkg::st_init_access) ? init_line : refill_q;

  assign cachereq_rdy   = state_q == cache_ctrl_pkg::st_idle;
  assign cacheresp_val  = state_q == cache_ctrl_pkg::st_resp_wait;
  assign cacheresp_type = req_type_q;
  assign cacheresp_data = resp_data_q;
  assign cacheresp_hit  = hit_q;

  assign memreq_write = state_q == cache_ctrl_pkg::st_evict_request;
  assign memreq_val   = memreq_write || state_q == cache_ctrl_pkg::st_refill_request;
  assign memreq_addr  = {(memreq_write ? victim_tag : line_addr), {ofs{1'b0}}};
  assign memreq_data  = rd_line;  // Victim line, ignored on refill
  assign memresp_rdy  = state_q == cache_ctrl_pkg::st_evict_wait ||
                        state_q == cache_ctrl_pkg::st_refill_wait;

endmodule

//--- blocking_cache.sv
// --------------------------------------------------
// Two-way blocking write-back cache, top level
// --------------------------------------------------

module blocking_cache #(
  parameter int num_sets = 8
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      cachereq_val,
  output logic                      cachereq_rdy,
  input  cache_ctrl_pkg::req_type_e cachereq_type,
  input  cache_geom_pkg::addr_t     cachereq_addr,
  input  cache_geom_pkg::word_t     cachereq_data,
  output logic                      cacheresp_val,
  input  logic                      cacheresp_rdy,
  output cache_ctrl_pkg::req_type_e cacheresp_type,
  output cache_geom_pkg::word_t     cacheresp_data,
  output logic                      cacheresp_hit,
  output logic                      memreq_val,
  input  logic                      memreq_rdy,
  output logic                      memreq_write,
  output cache_geom_pkg::addr_t     memreq_addr,
  output cache_geom_pkg::line_t     memreq_data,
  input  logic                      memresp_val,
  output logic                      memresp_rdy,
  input  cache_geom_pkg::line_t     memresp_data
);

  cache_geom_pkg::tag_t      line_addr, victim_tag;
  cache_geom_pkg::word_sel_t word_sel;
  cache_geom_pkg::word_t     wr_word, rd_word;
  cache_geom_pkg::line_t     wr_line, rd_line;
  logic install, set_dirty, touch, way;
  logic hit, hit_way, victim_way, victim_dirty;
  logic word_write, line_write;

  cache_ctrl ctrl_i (
    .clk, .reset,
    .cachereq_val, .cachereq_rdy, .cachereq_type, .cachereq_addr, .cachereq_data,
    .cacheresp_val, .cacheresp_rdy, .cacheresp_type, .cacheresp_data, .cacheresp_hit,
    .memreq_val, .memreq_rdy, .memreq_write, .memreq_addr, .memreq_data,
    .memresp_val, .memresp_rdy, .memresp_data,
    .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
    .rd_word, .rd_line,
    .line_addr, .install, .set_dirty, .touch, .way,
    .word_sel, .word_write, .line_write, .wr_word, .wr_line
  );

  cache_tag_store #(.num_sets(num_sets)) tag_store_i (
    .clk, .reset, .line_addr,
    .install, .set_dirty, .touch, .way,
    .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag
  );

  cache_data_store #(.num_sets(num_sets)) data_store_i (
    .clk, .line_addr, .way, .word_sel,
    .word_write, .line_write, .wr_word, .wr_line,
    .rd_word, .rd_line
  );

endmodule

//--- blocking_cache_asserts.sv
// --------------------------------------------------
// Handshake assertions bound to the cache top level
// --------------------------------------------------

module blocking_cache_asserts (
  input logic                      clk,
  input logic                      reset,
  input logic                      cachereq_rdy,
  input logic                      cacheresp_val,
  input logic                      cacheresp_rdy,
  input cache_ctrl_pkg::req_type_e cacheresp_type,
  input cache_geom_pkg::word_t     cacheresp_data,
  input logic                      cacheresp_hit,
  input logic                      memreq_val,
  input logic                      memreq_rdy,
  input logic                      memreq_write,
  input cache_geom_pkg::addr_t     memreq_addr,
  input cache_geom_pkg::line_t     memreq_data
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_count = 0;  // Read by the testbench at the end

  // Stalled response keeps its payload
  resp_hold: assert property (@(posedge clk) disable iff (reset)
    cacheresp_val && !cacheresp_rdy |=> cacheresp_val && $stable(cacheresp_type) &&
      $stable(cacheresp_data) && $stable(cacheresp_hit))
  else begin
    $error("Cache response changed while stalled");
    fail_count++;
  end

  // Refill data is don't care, so only write data must hold
  memreq_hold: assert property (@(posedge clk) disable iff (reset)
    memreq_val && !memreq_rdy |=> memreq_val && $stable(memreq_write) &&
      $stable(memreq_addr) && (!memreq_write || $stable(memreq_data)))
  else begin
    $error("Memory request dropped or changed while stalled");
    fail_count++;
  end

  req_resp_excl: assert property (@(posedge clk) disable iff (reset)
    !(cachereq_rdy && cacheresp_val))
  else begin
    $error("Request ready and response valid high together");
    fail_count++;
  end

endmodule

//--- blocking_cache_tb.sv
// --------------------------------------------------
// Blocking cache testbench with random traffic against
// a memory model and a flat reference word map
// --------------------------------------------------

module blocking_cache_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int max_wait = 200;  // Cycles allowed for any single handshake

  logic clk = 1'b0;
  logic reset, cachereq_val, cachereq_rdy, cacheresp_val, cacheresp_rdy, cacheresp_hit;
  logic memreq_val, memreq_rdy, memreq_write, memresp_val, memresp_rdy;
  cache_ctrl_pkg::req_type_e cachereq_type, cacheresp_type;
  cache_geom_pkg::addr_t     cachereq_addr, memreq_addr;
  cache_geom_pkg::word_t     cachereq_data, cacheresp_data;
  cache_geom_pkg::line_t     memreq_data, memresp_data;

  bit [31:0] mem_words [2048];  // Word-addressed memory model
  bit [31:0] ref_words [2048];  // Expected view through the cache
  bit        mem_pending;
  bit        resp_rdy_hold;     // Keeps cacheresp_rdy high when set
  int        mem_delay, mem_reqs, write_backs;

  blocking_cache #(.num_sets(8)) dut_i (.*);

  bind blocking_cache blocking_cache_asserts asserts_i (.*);

  always #5 clk = ~clk;

  // --------------------------------------------------
  // Error handling and checks
  // --------------------------------------------------

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "Simulation stopped after an error");
  endtask

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (actual !== expected)
      abort_run($sformatf("Fail %s: expected %0h, actual %0h", name, expected, actual));
  endtask

  // Word 0 sits in the low bits of a line
  function automatic cache_geom_pkg::line_t line_of(input logic [8:0] line, input bit from_ref);
    cache_geom_pkg::line_t l;
    for (int w = 0; w < 4; w++) begin
      l[w*32 +: 32] = from_ref ? ref_words[{line, w[1:0]}] : mem_words[{line, w[1:0]}];
    end
    return l;
  endfunction

  // --------------------------------------------------
  // One clock of memory model and response back-pressure
  // --------------------------------------------------

  task automatic tick();
    logic [8:0] line;
    @(posedge clk);
    line = memreq_addr[12:4];
    if (memresp_val && memresp_rdy) begin
      memresp_val <= 1'b0;
      memreq_rdy  <= 1'b1;
    end else if (mem_pending) begin
      if (mem_delay == 0) begin
        memresp_val <= 1'b1;
        mem_pending = 1'b0;
      end else begin
        mem_delay--;
      end
    end else if (memreq_val && memreq_rdy) begin
      if (memreq_write) begin
        // Victim shares the set of the pending request
        check_value("write-back address", 128'({19'd0, line[8:3], cachereq_addr[6:4], 4'd0}),
                    128'(memreq_addr));
        // Victim line must match what the cache has absorbed so far
        check_value("write-back data", line_of(line, 1'b1), memreq_data);
        for (int w = 0; w < 4; w++) begin
          mem_words[{line, w[1:0]}] = memreq_data[w*32 +: 32];
        end
        write_backs++;
      end else begin
        check_value("refill address", 128'({cachereq_addr[31:4], 4'd0}), 128'(memreq_addr));
      end
      memresp_data <= memreq_write ? '0 : line_of(line, 1'b0);
      memreq_rdy   <= 1'b0;  // One request at a time
      mem_pending = 1'b1;
      mem_delay   = $urandom_range(5, 0);
      mem_reqs++;
    end
    cacheresp_rdy <= resp_rdy_hold || ($urandom_range(3, 0) != 0);
  endtask

  task automatic send_request(input cache_ctrl_pkg::req_type_e kind, input logic [8:0] line,
                              input logic [1:0] wsel, input cache_geom_pkg::word_t data,
                              output cache_geom_pkg::word_t rdata, output logic rhit,
                              output int lat);
    int n;
    cachereq_val  <= 1'b1;
    cachereq_type <= kind;
    cachereq_addr <= {19'd0, line, wsel, 2'b00};
    cachereq_data <= data;
    n = 0;
    do begin
      tick();
      n++;
      if (n > max_wait) abort_run("Timeout waiting for the cache to accept a request");
    end while (!(cachereq_val && cachereq_rdy));
    cachereq_val <= 1'b0;
    lat = 0;  // Edges from acceptance to response transfer
    do begin
      tick();
      lat++;
      if (lat > max_wait) abort_run("Timeout waiting for the cache response");
    end while (!(cacheresp_val && cacheresp_rdy));
    check_value("response type", 128'(kind), 128'(cacheresp_type));
    rdata = cacheresp_data;
    rhit  = cacheresp_hit;
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial begin
    cache_geom_pkg::word_t     rdata, data;
    cache_ctrl_pkg::req_type_e kind;
    logic       rhit;
    logic [8:0] line;
    logic [1:0] wsel;
    int         lat, k;

    void'($urandom(96583));
    reset         <= 1'b1;
    cachereq_val  <= 1'b0;
    cachereq_type <= cache_ctrl_pkg::req_read;
    cachereq_addr <= '0;
    cachereq_data <= '0;
    cacheresp_rdy <= 1'b0;
    memreq_rdy    <= 1'b1;
    memresp_val   <= 1'b0;
    memresp_data  <= '0;
    repeat (16) tick();
    reset <= 1'b0;
    tick();
    check_value("reset cachereq_rdy", 128'(1), 128'(cachereq_rdy));
    check_value("reset memreq_val", 128'(0), 128'(memreq_val));
    check_value("reset cacheresp_val", 128'(0), 128'(cacheresp_val));
    check_value("reset memresp_rdy", 128'(0), 128'(memresp_rdy));

    // Init one word per set, then read all back without memory traffic
    for (int i = 0; i < 8; i++) begin
      line = {6'b100000, i[2:0]};
      data = $urandom();
      send_request(cache_ctrl_pkg::req_init, line, 2'd0, data, rdata, rhit, lat);
      check_value("init hit", 128'(0), 128'(rhit));
      ref_words[{line, 2'd0}] = data;
      mem_words[{line, 2'd0}] = data;  // Init stands for a word memory already holds
    end
    for (int i = 0; i < 8; i++) begin
      line = {6'b100000, i[2:0]};
      send_request(cache_ctrl_pkg::req_read, line, 2'd0, '0, rdata, rhit, lat);
      check_value("init read data", 128'(ref_words[{line, 2'd0}]), 128'(rdata));
      check_value("init read hit", 128'(1), 128'(rhit));
    end
    check_value("memory requests after init", 128'(0), 128'(mem_reqs));

    // Hit path takes tag check, access and response
    resp_rdy_hold = 1'b1;
    for (int i = 0; i < 4; i++) begin
      line = {6'b100000, i[2:0]};
      send_request(cache_ctrl_pkg::req_read, line, 2'd0, '0, rdata, rhit, lat);
      check_value("hit latency", 128'(3), 128'(lat));
    end
    resp_rdy_hold = 1'b0;

    // 64 lines squeezed into sets 2 and 5
    for (int n = 0; n < 400; n++) begin
      k    = $urandom_range(63, 0);
      line = {1'b0, k[5:1], k[0] ? 3'd5 : 3'd2};
      wsel = 2'($urandom_range(3, 0));
      data = $urandom();
      kind = $urandom_range(1, 0) ? cache_ctrl_pkg::req_write : cache_ctrl_pkg::req_read;
      send_request(kind, line, wsel, data, rdata, rhit, lat);
      if (kind == cache_ctrl_pkg::req_write) ref_words[{line, wsel}] = data;
      else check_value("random read data", 128'(ref_words[{line, wsel}]), 128'(rdata));
    end
    check_value("write-backs seen", 128'(1), 128'(write_backs != 0));

    for (int n = 0; n < 16; n++) begin
      k    = $urandom_range(63, 0);
      line = {1'b0, k[5:1], k[0] ? 3'd5 : 3'd2};
      wsel = 2'($urandom_range(3, 0));
      data = $urandom();
      send_request(cache_ctrl_pkg::req_write, line, wsel, data, rdata, rhit, lat);
      ref_words[{line, wsel}] = data;
      send_request(cache_ctrl_pkg::req_read, line, wsel, '0, rdata, rhit, lat);
      check_value("read after write hit", 128'(1), 128'(rhit));
      check_value("read after write data", 128'(data), 128'(rdata));
    end

    if (dut_i.asserts_i.fail_count == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      abort_run("Handshake assertions failed during the run");
    end
  end

endmodule

//--- blocking_cache.f
cache_geom_pkg.sv
cache_ctrl_pkg.sv
cache_tag_store.sv
cache_data_store.sv
cache_ctrl.sv
blocking_cache.sv
blocking_cache_asserts.sv
blocking_cache_tb.sv

//--- Makefile
# Verilator flow for the blocking cache

VERILATOR ?= verilator
FILELIST  ?= blocking_cache.f
TB_TOP    ?= blocking_cache_tb
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= ** PASS **

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
